// ==== sim.f ====
alut_mac_pkg.sv
alut_table_pkg.sv
alut_mem_if.sv
alut_mem.sv
alut_addr_checker.sv
alut_age_checker.sv
alut_top.sv
alut_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the alut testbench with verilator, run it, decide from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module alut_tb \
   -f sim.f -o alut_sim \
   && ./obj_dir/alut_sim 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }
grep -q "^>>> PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== alut_tb.sv ====
/*
 * alut testbench
 *   clock, reset, random frames over a small mac pool
 *   reference table model with learning and aging
 *   check task and cycle limit
 */

module alut_tb
   import alut_mac_pkg::*;
   import alut_table_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int POOL_SIZE      = 24;
   localparam int TIMEOUT_CYCLES = 12000;   // covers clear, ~400 frames and 4 sweeps with margin

   logic            pclk5;
   logic            rst;
   logic            check_valid;
   mac_t            src_mac;
   mac_t            dst_mac;
   port_t           src_port;
   logic            check_busy;
   logic            result_valid;
   logic            result_hit;
   port_t           result_port;
   logic            time_tick;
   stamp_t          age_limit;
   logic            sweep_start;
   logic            sweep_busy;
   logic            sweep_done;
   logic [HASH_W:0] aged_count;

   int     seed = 32'h5786d5ea;
   int     cycle_count;
   mac_t   pool [POOL_SIZE];       // stations used by the traffic
   entry_t model [TABLE_DEPTH];    // expected table indexed by hash
   stamp_t model_time;             // ticks sent so far

   alut_top i_dut (.*);

   initial
   begin
      pclk5 = 1'b0;
      forever #2 pclk5 = ~pclk5;   // 4 ns period
   end

   // ------------------------------------------------------------
   // run limit
   // ------------------------------------------------------------
   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge pclk5);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "cycle limit reached");
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("Error %s: expected %0h, actual %0h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic send_tick();
      @(posedge pclk5);
      time_tick <= 1'b1;
      @(posedge pclk5);
      time_tick <= 1'b0;
      model_time = model_time + 1;   // curr_time moved on this edge
   endtask

   // one frame with the result checked against the table before learning
   task automatic run_frame(input mac_t src, input mac_t dst, input port_t sport,
                            input string name, output logic hit);
      entry_t e;
      logic   exp_hit;
      port_t  exp_port;
      int     n;
      e        = model[mac_hash(dst)];
      exp_hit  = e.valid && (e.mac == dst);   // full mac compare so a collision misses
      exp_port = exp_hit ? e.port : '0;
      @(posedge pclk5);
      check_valid <= 1'b1;
      src_mac     <= src;
      dst_mac     <= dst;
      src_port    <= sport;
      @(posedge pclk5);
      check_valid <= 1'b0;
      for (n = 1; n <= 4; n++)
      begin
         @(negedge pclk5);
         check_value({name, " check_busy"}, 1, check_busy);
         check_value({name, " result_valid"}, (n == 4), result_valid);   // 4th cycle only
      end
      check_value({name, " result_hit"}, exp_hit, result_hit);
      check_value({name, " result_port"}, exp_port, result_port);
      hit = result_hit;
      // source learned in the same cycle
      e.valid = 1'b1;
      e.mac   = src;
      e.port  = sport;
      e.stamp = model_time;
      model[mac_hash(src)] = e;   // overwrite on collision
      @(negedge pclk5);
      check_value({name, " idle busy"}, 0, check_busy);
      check_value({name, " idle result_valid"}, 0, result_valid);
   endtask

   task automatic random_traffic(input int count, input string name);
      int   k;
      int   s;
      int   d;
      logic h;
      for (k = 0; k < count; k++)
      begin
         if ($unsigned($random(seed)) % 4 == 0)
            send_tick();                          // time moves now and then
         s = $unsigned($random(seed)) % POOL_SIZE;
         d = $unsigned($random(seed)) % POOL_SIZE;   // may equal s
         run_frame(pool[s], pool[d], port_t'($random(seed)), name, h);
      end
   endtask

   // look up every pool mac and learn it back
   task automatic probe_pool(input string name);
      int   k;
      logic h;
      for (k = 0; k < POOL_SIZE; k++)
         run_frame(pool[k], pool[k], port_t'(k), name, h);
   endtask

   task automatic run_sweep(input stamp_t limit, input string name);
      int     k;
      int     n;
      int     exp_count;
      stamp_t age;
      exp_count = 0;
      for (k = 0; k < TABLE_DEPTH; k++)
      begin
         age = model_time - model[k].stamp;   // modulo 2^32
         if (model[k].valid && (age > limit))
         begin
            model[k] = '0;                    // retired
            exp_count++;
         end
      end
      @(posedge pclk5);
      age_limit   <= limit;
      sweep_start <= 1'b1;
      @(posedge pclk5);
      sweep_start <= 1'b0;
      n = 0;
      @(negedge pclk5);
      while (sweep_busy)
      begin
         check_value({name, " early done"}, 0, sweep_done);
         n++;
         @(negedge pclk5);
      end
      check_value({name, " length"}, 512, n);   // two cycles per entry
      check_value({name, " sweep_done"}, 1, sweep_done);
      check_value({name, " aged_count"}, exp_count, aged_count);
      @(negedge pclk5);
      check_value({name, " done pulse"}, 0, sweep_done);
      check_value({name, " count held"}, exp_count, aged_count);
   endtask

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial
   begin
      int   i;
      int   n;
      logic hit;
      rst         = 1'b1;
      check_valid = 1'b0;
      src_mac     = '0;
      dst_mac     = '0;
      src_port    = '0;
      time_tick   = 1'b0;
      age_limit   = '0;
      sweep_start = 1'b0;
      model_time  = '0;
      for (i = 0; i < TABLE_DEPTH; i++)
         model[i] = '0;
      for (i = 0; i < POOL_SIZE; i++)
      begin
         pool[i][47:32] = 16'($random(seed));
         pool[i][31:0]  = $random(seed);
      end
      pool[20] = pool[0] ^ 48'h0000_0000_a5a5;   // same byte in two lanes cancels in the xor
      pool[21] = pool[1] ^ 48'h3c00_003c_0000;
      check_value("pool hash pair 0", mac_hash(pool[0]), mac_hash(pool[20]));
      check_value("pool hash pair 1", mac_hash(pool[1]), mac_hash(pool[21]));

      repeat (3) @(posedge pclk5);
      rst <= 1'b0;

      // reset clear writes one entry per cycle
      n = 0;
      @(negedge pclk5);
      while (sweep_busy)
      begin
         check_value("clear sweep_done", 0, sweep_done);
         check_value("clear check_busy", 0, check_busy);
         check_value("clear result_valid", 0, result_valid);
         n++;
         @(negedge pclk5);
      end
      check_value("clear length", 256, n);
      check_value("clear end no done", 0, sweep_done);   // clear ends without a pulse

      for (i = 0; i < 4; i++)
      begin
         run_frame(pool[i], pool[i + 12], 2'd1, "empty lookup", hit);
         check_value("empty table hit", 0, hit);
      end

      random_traffic(150, "learn lookup");

      // ---------------- collision overwrite ----------------
      run_frame(pool[0], pool[5], 2'd2, "collision learn", hit);
      run_frame(pool[20], pool[6], 2'd3, "collision overwrite", hit);
      run_frame(pool[20], pool[0], 2'd3, "collision old", hit);
      check_value("collision old miss", 0, hit);
      run_frame(pool[20], pool[20], 2'd3, "collision new", hit);
      check_value("collision new hit", 1, hit);

      // ---------------- aging sweeps ----------------
      for (i = 0; i < 3; i++)
      begin
         random_traffic(50, "age traffic");
         repeat (8) send_tick();
         run_sweep($unsigned($random(seed)) % (model_time + 1), "age sweep");
         probe_pool("age probe");
      end

      // relearning refreshes a stamp that would age at limit 10
      run_frame(pool[10], pool[11], 2'd1, "refresh learn", hit);
      repeat (20) send_tick();
      run_frame(pool[10], pool[12], 2'd1, "refresh relearn", hit);
      repeat (5) send_tick();
      run_sweep(32'd10, "refresh sweep");
      run_frame(pool[13], pool[10], 2'd0, "refresh lookup", hit);
      check_value("refresh survives", 1, hit);

      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== alut_top.sv ====
/*
 * address lookup table top level
 *   table ram with two ports
 *   address checker and age checker
 */

module alut_top
   import alut_mac_pkg::*;
   import alut_table_pkg::*;
(
   input  logic            pclk5,
   input  logic            rst,

   // frame check
   input  logic            check_valid,
   input  mac_t            src_mac,
   input  mac_t            dst_mac,
   input  port_t           src_port,
   output logic            check_busy,
   output logic            result_valid,
   output logic            result_hit,
   output port_t           result_port,

   // aging
   input  logic            time_tick,
   input  stamp_t          age_limit,
   input  logic            sweep_start,
   output logic            sweep_busy,
   output logic            sweep_done,
   output logic [HASH_W:0] aged_count
);

   // ------------------------------------------------------------
   // ram ports and shared time
   // ------------------------------------------------------------
   alut_mem_if add_port ();   // address checker to ram
   alut_mem_if age_port ();   // age checker to ram

   stamp_t curr_time;         // stamp for learned entries

   // ------------------------------------------------------------
   // instances
   // ------------------------------------------------------------
   alut_mem i_mem (
      .pclk5    (pclk5),
      .add_port (add_port.mem),
      .age_port (age_port.mem)
   );

   alut_addr_checker i_addr_checker (
      .pclk5        (pclk5),
      .rst          (rst),
      .check_valid  (check_valid),
      .src_mac      (src_mac),
      .dst_mac      (dst_mac),
      .src_port     (src_port),
      .curr_time    (curr_time),
      .check_busy   (check_busy),
      .result_valid (result_valid),
      .result_hit   (result_hit),
      .result_port  (result_port),
      .mem          (add_port.client)
   );

   alut_age_checker i_age_checker (
      .pclk5       (pclk5),
      .rst         (rst),
      .time_tick   (time_tick),
      .sweep_start (sweep_start),
      .age_limit   (age_limit),
      .curr_time   (curr_time),
      .sweep_busy  (sweep_busy),
      .sweep_done  (sweep_done),
      .aged_count  (aged_count),
      .mem         (age_port.client)
   );

endmodule

// ==== alut_age_checker.sv ====
/*
 * age checker
 *   table time counter on time_tick
 *   clear pass over all entries after reset
 *   two cycle per entry aging sweep with retired count
 */

module alut_age_checker
   import alut_mac_pkg::*;
   import alut_table_pkg::*;
(
   input  logic            pclk5,
   input  logic            rst,
   input  logic            time_tick,     // advance table time
   input  logic            sweep_start,   // taken only when not busy
   input  stamp_t          age_limit,     // oldest age kept, in ticks
   output stamp_t          curr_time,
   output logic            sweep_busy,
   output logic            sweep_done,    // one cycle after the last entry
   output logic [HASH_W:0] aged_count,    // up to 256
   alut_mem_if.client      mem
);

   // ------------------------------------------------------------
   // declarations
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      S_CLEAR,   // one invalid write per cycle
      S_IDLE,
      S_READ,    // sweep read
      S_JUDGE    // retire or skip
   } state_t;

   state_t state;
   hash_t  sweep_addr;    // shared by clear and sweep
   stamp_t entry_age;
   logic   last_addr;
   logic   aged;          // entry under judgement is retired

   assign last_addr = (sweep_addr == hash_t'(TABLE_DEPTH - 1));
   assign entry_age = curr_time - mem.rdata.stamp;   // modulo, survives wrap

   // strictly older than the limit
   assign aged = (state == S_JUDGE) && mem.rdata.valid && (entry_age > age_limit);

   // ------------------------------------------------------------
   // table time
   // ------------------------------------------------------------
   always_ff @(posedge pclk5)
   begin
      if (rst)
         curr_time <= '0;
      else if (time_tick)
         curr_time <= curr_time + 1'b1;
   end

   // ------------------------------------------------------------
   // clear and sweep control
   // ------------------------------------------------------------
   always_ff @(posedge pclk5)
   begin
      if (rst)
      begin
         state      <= S_CLEAR;   // clear starts as rst falls
         sweep_addr <= '0;
         aged_count <= '0;
         sweep_done <= 1'b0;
      end
      else
      begin
         sweep_done <= 1'b0;      // pulse
         case (state)
            S_CLEAR:
            begin
               sweep_addr <= sweep_addr + 1'b1;   // wraps to 0 at the end
               if (last_addr)
                  state <= S_IDLE;                 // no done pulse for the clear
            end
            S_IDLE:
            begin
               if (sweep_start)
               begin
                  state      <= S_READ;
                  sweep_addr <= '0;
                  aged_count <= '0;   // previous count held until now
               end
            end
            S_READ: state <= S_JUDGE;
            S_JUDGE:
            begin
               if (aged)
                  aged_count <= aged_count + 1'b1;
               sweep_addr <= sweep_addr + 1'b1;
               if (last_addr)
               begin
                  state      <= S_IDLE;
                  sweep_done <= 1'b1;   // count final here
               end
               else
                  state <= S_READ;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // table port
   // ------------------------------------------------------------
   assign mem.addr   = sweep_addr;
   assign mem.write  = (state == S_CLEAR) || aged;   // idle judge cycle just rereads
   assign mem.wdata  = EMPTY_ENTRY;                  // valid low

   assign sweep_busy = (state != S_IDLE);

endmodule

// ==== alut_addr_checker.sv ====
/*
 * address checker
 *   per frame destination lookup
 *   source learning with current table time
 *   four cycle sequence, result on the last
 */

module alut_addr_checker
   import alut_mac_pkg::*;
   import alut_table_pkg::*;
(
   input  logic       pclk5,
   input  logic       rst,
   input  logic       check_valid,   // frame strobe, only taken when idle
   input  mac_t       src_mac,
   input  mac_t       dst_mac,
   input  port_t      src_port,      // ingress port of the frame
   input  stamp_t     curr_time,     // from the age checker
   output logic       check_busy,
   output logic       result_valid,
   output logic       result_hit,
   output port_t      result_port,
   alut_mem_if.client mem
);

   // ------------------------------------------------------------
   // declarations
   // ------------------------------------------------------------
   typedef enum logic [2:0] {
      S_IDLE,     // waiting for check_valid
      S_RD_DST,   // destination address on the port
      S_WAIT,     // ram latency
      S_CMP,      // judge returned entry
      S_WR_SRC    // learn source, report result
   } state_t;

   state_t state;

   // frame fields held for the whole check
   mac_t   src_mac_q;
   mac_t   dst_mac_q;
   port_t  src_port_q;

   logic   hit_q;       // destination found
   port_t  port_q;      // its port, zero on miss
   logic   dst_match;   // returned entry is the destination
   logic   accept;      // strobe taken this cycle

   assign accept = (state == S_IDLE) && check_valid;

   // valid bit and full mac, the hash alone can collide
   assign dst_match = mem.rdata.valid && (mem.rdata.mac == dst_mac_q);

   // ------------------------------------------------------------
   // sequencer
   // ------------------------------------------------------------
   always_ff @(posedge pclk5)
   begin
      if (rst)
      begin
         state <= S_IDLE;
      end
      else
      begin
         case (state)
            S_IDLE:   if (accept) state <= S_RD_DST;
            S_RD_DST: state <= S_WAIT;
            S_WAIT:   state <= S_CMP;
            S_CMP:    state <= S_WR_SRC;
            S_WR_SRC: state <= S_IDLE;      // back to back frames need one idle
            default:  state <= S_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // frame fields and lookup result
   // ------------------------------------------------------------
   always_ff @(posedge pclk5)
   begin
      if (accept)
      begin
         src_mac_q  <= src_mac;
         dst_mac_q  <= dst_mac;
         src_port_q <= src_port;
      end

      // rdata still holds the destination read here
      if (state == S_CMP)
      begin
         hit_q  <= dst_match;
         port_q <= dst_match ? mem.rdata.port : '0;
      end
   end

   // ------------------------------------------------------------
   // table port
   // ------------------------------------------------------------
   always_comb
   begin
      mem.write = (state == S_WR_SRC);    // learn in the last cycle only

      // destination read everywhere else, address held through the wait
      if (state == S_WR_SRC)
      begin
         mem.addr = mac_hash(src_mac_q);
      end
      else
      begin
         mem.addr = mac_hash(dst_mac_q);
      end

      // learned entry, a collision just overwrites
      mem.wdata.valid = 1'b1;
      mem.wdata.mac   = src_mac_q;
      mem.wdata.port  = src_port_q;
      mem.wdata.stamp = curr_time;      // refreshes the age of a known station
   end

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------
   assign check_busy   = (state != S_IDLE);     // four cycles per frame
   assign result_valid = (state == S_WR_SRC);   // same cycle as the learn write
   assign result_hit   = hit_q;
   assign result_port  = port_q;

endmodule

// ==== alut_mem.sv ====
/*
 * address table ram
 *   256 entries, two synchronous ports
 *   each port reads or writes once per cycle
 */

module alut_mem
   import alut_table_pkg::*;
(
   input logic    pclk5,
   alut_mem_if.mem add_port,   // address checker side
   alut_mem_if.mem age_port    // age checker side
);

   entry_t mem_array [TABLE_DEPTH];   // contents cleared by the age checker

   // ------------------------------------------------------------
   // both ports, read registers rdata, write leaves it alone
   // ------------------------------------------------------------
   always_ff @(posedge pclk5)
   begin
      // address checker port
      if (add_port.write)
      begin
         mem_array[add_port.addr] <= add_port.wdata;
      end
      else
      begin
         add_port.rdata <= mem_array[add_port.addr];   // lookup
      end

      // age checker port, never the same address as above in one cycle
      if (age_port.write)
      begin
         mem_array[age_port.addr] <= age_port.wdata;   // clear or retire
      end
      else
      begin
         age_port.rdata <= mem_array[age_port.addr];   // sweep read
      end
   end

endmodule

// ==== alut_mem_if.sv ====
/*
 * one port of the address table memory
 *   client modport for the checkers
 *   mem modport for the ram
 */

interface alut_mem_if
   import alut_table_pkg::*;
();

   hash_t  addr;    // entry address
   logic   write;   // high = write, low = read
   entry_t wdata;   // entry to store
   entry_t rdata;   // registered read, one cycle after addr

   // checker side
   modport client (output addr, write, wdata, input rdata);

   // ram side
   modport mem (input addr, write, wdata, output rdata);

endinterface

// ==== alut_table_pkg.sv ====
/*
 * address table layout
 *   entry_t, depth and hash width
 *   empty entry used by clear and aging
 *   mac_hash xor fold of a mac into a table address
 */

package alut_table_pkg;

   import alut_mac_pkg::*;

   // ------------------------------------------------------------
   // geometry
   // ------------------------------------------------------------
   localparam int TABLE_DEPTH = 256;            // one entry per hash value
   localparam int HASH_W      = 8;              // log2 of depth

   typedef logic [HASH_W-1:0] hash_t;           // table address

   // one table word, 83 bits, valid in the msb
   typedef struct packed {
      logic   valid;   // entry holds a learned station
      mac_t   mac;     // full mac, hash alone is ambiguous
      port_t  port;    // port the station was seen on
      stamp_t stamp;   // table time of last learning
   } entry_t;

   // written by the clear pass and by aging
   localparam entry_t EMPTY_ENTRY = '0;

   // ------------------------------------------------------------
   // hash
   // ------------------------------------------------------------
   // xor of the six mac bytes, cheap and spreads well enough
   function automatic hash_t mac_hash(input mac_t mac);
      hash_t h;
      h = '0;
      for (int i = 0; i < MAC_W / HASH_W; i++)
      begin
         h = h ^ mac[i*HASH_W +: HASH_W];   // fold next byte in
      end
      return h;
   endfunction

endpackage

// ==== alut_mac_pkg.sv ====
/*
 * switch port address types
 *   mac_t    ethernet station address
 *   port_t   switch port number
 *   stamp_t  table time in ticks
 */

package alut_mac_pkg;

   // ------------------------------------------------------------
   // field widths
   // ------------------------------------------------------------
   localparam int MAC_W   = 48;   // ieee 802 mac
   localparam int PORT_W  = 2;    // four ports on this switch
   localparam int STAMP_W = 32;   // wraps after 2^32 ticks

   // ------------------------------------------------------------
   // types
   // ------------------------------------------------------------
   typedef logic [MAC_W-1:0]   mac_t;     // byte 0 in bits 7:0
   typedef logic [PORT_W-1:0]  port_t;
   typedef logic [STAMP_W-1:0] stamp_t;   // compared modulo 2^32

endpackage
